/* project.f */
logic/bridge_pkg.sv
logic/aligned_req_if.sv
logic/lane_aligner.sv
logic/wait_timer.sv
logic/access_fsm.sv
logic/harvard_avalon_bridge.sv
tests/clock_gen.sv
tests/avalon_slave_model.sv
tests/bridge_tb.sv

/* tests/bridge_tb.sv */
`timescale 1ns/1ns

module bridge_tb;
  import bridge_pkg::*;

  localparam int NUM_TRANS      = 200;
  localparam int TIMEOUT_CYCLES = NUM_TRANS * 12 + 100;

  logic       clk;
  logic       reset;
  word_t      av_address;
  word_t      av_writedata;
  word_t      av_readdata;
  byte_en_t   av_byteenable;
  logic       av_read;
  logic       av_write;
  logic       av_waitrequest;
  logic       clk_enable;
  logic       bus_error;
  word_t      instr_address;
  logic       instr_read;
  word_t      instr_readdata;
  word_t      data_address;
  logic       data_read;
  logic       data_write;
  word_t      data_writedata;
  word_t      data_readdata;
  logic [1:0] wait_cycles;
  logic       stuck;

  word_t shadow [0:255];  // expected memory contents
  word_t exp_dread;
  word_t exp_iread;
  logic  exp_error;
  int    word_errors;
  int    enable_errors;
  int    flag_errors;
  int    other_errors;
  int    cycle_count = 0;

  clock_gen i_clk (.clk(clk), .reset(reset));
  harvard_avalon_bridge i_dut (.*);
  avalon_slave_model i_mem (.*);

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      word_errors++;
      $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_enables(input string name, input byte_en_t got, input byte_en_t exp);
    if (got !== exp)
    begin
      enable_errors++;
      $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      flag_errors++;
      $display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // lanes from the offset upward take the shifted write data
  task automatic apply_write(input word_t addr, input word_t wdata);
    word_t shifted;
    int    lane;
    shifted = wdata << (8 * addr[1:0]);
    for (lane = addr[1:0]; lane < 4; lane++)
      shadow[addr[9:2]][8*lane +: 8] = shifted[8*lane +: 8];
  endtask

  // one request held until HALTED, then one idle cycle
  task automatic run_access(input logic rd, input logic wr, input logic ir,
                            input word_t daddr, input word_t wdata, input word_t iaddr);
    logic saw_instr;
    int   stall;
    data_read      = rd;
    data_write     = wr;
    instr_read     = ir;
    data_address   = daddr;
    data_writedata = wdata;
    instr_address  = iaddr;
    @(negedge clk);
    check_flag("clk_enable", clk_enable, 1'b0);
    check_flag("av_write", av_write, wr);
    check_word("av_address", av_address, (rd || wr) ? {daddr[31:2], 2'b00} : iaddr);
    if (wr)
    begin
      check_word("av_writedata", av_writedata, wdata << (8 * daddr[1:0]));
      check_enables("av_byteenable", av_byteenable, 4'b1111 << daddr[1:0]);
    end
    saw_instr = 1'b0;
    stall     = 0;
    while (!clk_enable)
    begin
      if (av_read && (av_address == iaddr) && (stall > 0))
        saw_instr = 1'b1;  // instruction read shown after the data access
      stall++;
      @(negedge clk);
    end
    if (stuck)
    begin
      exp_error = 1'b1;
      if (saw_instr)
      begin
        other_errors++;
        $display("instruction fetch was issued after a timed-out data access");
      end
      if (stall < BUS_TIMEOUT_CYCLES)
      begin
        other_errors++;
        $display("stuck access ended after %0d cycles, before the watchdog limit", stall);
      end
    end
    else
    begin
      if (rd)
        exp_dread = shadow[daddr[9:2]] >> (8 * daddr[1:0]);
      if (wr)
        apply_write(daddr, wdata);
      if (ir)
        exp_iread = shadow[iaddr[9:2]];  // sees a write made earlier in this stall
      if (ir && !saw_instr)
      begin
        other_errors++;
        $display("instruction read never appeared on the bus at t=%0t", $time);
      end
    end
    check_word("data_readdata", data_readdata, exp_dread);
    check_word("instr_readdata", instr_readdata, exp_iread);
    check_flag("bus_error", bus_error, exp_error);
    @(posedge clk);
    #2;
    data_read  = 1'b0;
    data_write = 1'b0;
    instr_read = 1'b0;
    @(negedge clk);
    check_flag("clk_enable", clk_enable, 1'b1);
    check_flag("av_read", av_read, 1'b0);
    check_flag("av_write", av_write, 1'b0);
    @(posedge clk);
    #2;
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
    begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial
  begin
    int          kind;
    int          i;
    word_t       daddr;
    word_t       iaddr;
    void'($urandom(919));
    data_read      = 1'b0;
    data_write     = 1'b0;
    instr_read     = 1'b0;
    data_address   = '0;
    data_writedata = '0;
    instr_address  = '0;
    wait_cycles    = 2'd0;
    stuck          = 1'b0;
    word_errors    = 0;
    enable_errors  = 0;
    flag_errors    = 0;
    other_errors   = 0;
    exp_dread      = '0;
    exp_iread      = '0;
    exp_error      = 1'b0;
    wait (!reset);
    for (i = 0; i < 256; i++)
      shadow[i] = i_mem.mem[i];  // start from the slave's initial contents
    @(negedge clk);
    check_flag("clk_enable", clk_enable, 1'b1);
    check_flag("bus_error", bus_error, 1'b0);
    check_word("data_readdata", data_readdata, '0);
    check_word("instr_readdata", instr_readdata, '0);
    @(posedge clk);
    #2;
    for (i = 0; i < NUM_TRANS; i++)
    begin
      kind        = $urandom_range(4, 0);
      daddr       = $urandom_range(127, 0);  // small window so writes get read back
      iaddr       = $urandom_range(31, 0) << 2;
      wait_cycles = $urandom_range(3, 0);
      run_access((kind == 1) || (kind == 3), (kind == 2) || (kind == 4),
                 (kind == 0) || (kind == 3) || (kind == 4), daddr, $urandom, iaddr);
    end
    // slave never releases waitrequest, watchdog has to end the access
    stuck = 1'b1;
    run_access(1'b1, 1'b0, 1'b1, 32'h0000_0105, '0, 32'h0000_0300);
    stuck = 1'b0;
    run_access(1'b1, 1'b0, 1'b0, 32'h0000_0042, '0, '0);  // bus_error stays set
    $display("errors: word %0d, enable %0d, flag %0d, other %0d",
             word_errors, enable_errors, flag_errors, other_errors);
    if ((word_errors + enable_errors + flag_errors + other_errors) == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* tests/avalon_slave_model.sv */
`timescale 1ns/1ns

module avalon_slave_model (
  input  logic                 clk,
  input  bridge_pkg::word_t    av_address,
  input  logic                 av_read,
  input  logic                 av_write,
  input  bridge_pkg::word_t    av_writedata,
  input  bridge_pkg::byte_en_t av_byteenable,
  output bridge_pkg::word_t    av_readdata,
  output logic                 av_waitrequest,
  input  logic [1:0]           wait_cycles,
  input  logic                 stuck
);
  import bridge_pkg::*;

  word_t       mem [0:255];
  logic [7:0]  index;
  logic        active;
  int unsigned held;  // wait cycles already spent on the current request

  assign index          = av_address[9:2];
  assign active         = av_read || av_write;
  assign av_waitrequest = active && (stuck || (held < wait_cycles));
  assign av_readdata    = mem[index];  // valid in the completing cycle

  // every word differs, built from the whole word index
  initial
  begin : fill_mem
    int i;
    for (i = 0; i < 256; i++)
      mem[i] = (word_t'(i) * 32'h9E37_79B1) ^ 32'h0F1E_2D3C;
  end

  always @(posedge clk)
  begin : bus_side
    int lane;
    if (!active || !av_waitrequest)
      held <= 0;  // new request or finished one
    else
      held <= held + 1;
    if (av_write && !av_waitrequest)
    begin
      for (lane = 0; lane < 4; lane++)
      begin
        if (av_byteenable[lane])
          mem[index][8*lane +: 8] <= av_writedata[8*lane +: 8];
      end
    end
  end

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial
  begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #2 reset = 1'b0;  // released just after the tenth edge
  end

endmodule

/* logic/harvard_avalon_bridge.sv */
`timescale 1ns/1ns

module harvard_avalon_bridge (
  input  logic                 clk,
  input  logic                 reset,

  // Avalon memory bus
  output bridge_pkg::word_t    av_address,
  output logic                 av_write,
  output logic                 av_read,
  input  logic                 av_waitrequest,
  output bridge_pkg::word_t    av_writedata,
  output bridge_pkg::byte_en_t av_byteenable,
  input  bridge_pkg::word_t    av_readdata,

  // processor stall
  output logic                 clk_enable,

  // instruction port
  input  bridge_pkg::word_t    instr_address,
  input  logic                 instr_read,
  output bridge_pkg::word_t    instr_readdata,

  // data port
  input  bridge_pkg::word_t    data_address,
  input  logic                 data_write,
  input  logic                 data_read,
  input  bridge_pkg::word_t    data_writedata,
  output bridge_pkg::word_t    data_readdata,

  output logic                 bus_error   // sticky watchdog flag
);

  aligned_req_if req_if ();

  logic capture_data;
  logic capture_instr;
  logic waiting;
  logic restart;
  logic expired;

  lane_aligner i_lane_aligner (
    .clk            (clk),
    .reset          (reset),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .av_readdata    (av_readdata),
    .capture_data   (capture_data),
    .capture_instr  (capture_instr),
    .req            (req_if.aligner),
    .data_readdata  (data_readdata),
    .instr_readdata (instr_readdata)
  );

  access_fsm i_access_fsm (
    .clk            (clk),
    .reset          (reset),
    .data_read      (data_read),
    .data_write     (data_write),
    .instr_read     (instr_read),
    .instr_address  (instr_address),
    .av_waitrequest (av_waitrequest),
    .req            (req_if.fsm),
    .expired        (expired),
    .av_address     (av_address),
    .av_writedata   (av_writedata),
    .av_byteenable  (av_byteenable),
    .av_read        (av_read),
    .av_write       (av_write),
    .clk_enable     (clk_enable),
    .capture_data   (capture_data),
    .capture_instr  (capture_instr),
    .waiting        (waiting),
    .restart        (restart),
    .bus_error      (bus_error)
  );

  wait_timer i_wait_timer (
    .clk     (clk),
    .reset   (reset),
    .waiting (waiting),
    .restart (restart),
    .expired (expired)
  );

endmodule

/* logic/access_fsm.sv */
`timescale 1ns/1ns

module access_fsm (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 data_read,
  input  logic                 data_write,
  input  logic                 instr_read,
  input  bridge_pkg::word_t    instr_address,
  input  logic                 av_waitrequest,
  aligned_req_if.fsm           req,
  input  logic                 expired,
  output bridge_pkg::word_t    av_address,
  output bridge_pkg::word_t    av_writedata,
  output bridge_pkg::byte_en_t av_byteenable,
  output logic                 av_read,
  output logic                 av_write,
  output logic                 clk_enable,
  output logic                 capture_data,
  output logic                 capture_instr,
  output logic                 waiting,
  output logic                 restart,
  output logic                 bus_error
);
  import bridge_pkg::*;

  bus_state_t state;
  bus_state_t state_next;
  logic       data_req;       // exactly one of data_read, data_write
  logic       data_is_write;  // direction latched when the data access starts
  logic       in_fetch;
  logic       timed_out;

  assign data_req  = data_read ^ data_write;
  assign in_fetch  = (state == FETCH_DATA) || (state == FETCH_INSTR);
  assign timed_out = in_fetch && av_waitrequest && expired;
  assign waiting   = in_fetch && av_waitrequest;

  // completion strobes for the readback registers, never on a timeout
  assign capture_data  = (state == FETCH_DATA) && !av_waitrequest && !data_is_write;
  assign capture_instr = (state == FETCH_INSTR) && !av_waitrequest;

  // clears the wait timer on every entry into a fetch state
  assign restart = (state_next != state) &&
                   ((state_next == FETCH_DATA) || (state_next == FETCH_INSTR));

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
      begin
        if (data_req)
          state_next = FETCH_DATA;  // data goes first
        else if (instr_read)
          state_next = FETCH_INSTR;
      end
      FETCH_DATA:
      begin
        if (timed_out)
          state_next = HALTED;  // abandoned, no instruction fetch
        else if (!av_waitrequest)
          state_next = instr_read ? INSTR_SET : HALTED;
      end
      INSTR_SET:
      begin
        state_next = FETCH_INSTR;
      end
      FETCH_INSTR:
      begin
        if (timed_out || !av_waitrequest)
          state_next = HALTED;
      end
      HALTED:
      begin
        state_next = IDLE;  // processor runs for this one cycle
      end
      default:
      begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= IDLE;
      data_is_write <= 1'b0;
      bus_error     <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if ((state == IDLE) && data_req)
        data_is_write <= data_write;
      if (timed_out)
        bus_error <= 1'b1;  // sticky until reset
    end
  end

  // bus drive and stall per state
  always_comb
  begin
    clk_enable    = 1'b0;
    av_address    = instr_address;
    av_writedata  = '0;
    av_byteenable = 4'b1111;
    av_read       = 1'b0;
    av_write      = 1'b0;
    case (state)
      IDLE:
      begin
        clk_enable = !(data_req || instr_read);  // stall as soon as a request shows
        if (data_req)
        begin
          av_address    = req.address;
          av_writedata  = req.writedata;
          av_byteenable = req.byteenable;
          av_read       = data_read;
          av_write      = data_write;
        end
        else if (instr_read)
        begin
          av_read = 1'b1;
        end
      end
      FETCH_DATA:
      begin
        av_address    = req.address;
        av_writedata  = req.writedata;
        av_byteenable = req.byteenable;
        av_read       = !data_is_write;
        av_write      = data_is_write;
      end
      INSTR_SET, FETCH_INSTR:
      begin
        av_read = 1'b1;  // whole-word instruction read
      end
      HALTED:
      begin
        clk_enable = 1'b1;
      end
      default:
      begin
        clk_enable = 1'b1;
      end
    endcase
  end

  a_one_command: assert property (
    @(posedge clk) disable iff (reset)
      !(av_read && av_write)
  ) else $error("access_fsm: read and write asserted together");

  // Avalon rule, the processor must also hold its request during the stall
  a_hold_on_wait: assert property (
    @(posedge clk) disable iff (reset)
      (in_fetch && av_waitrequest && !expired) |=>
        $stable(av_address) && $stable(av_writedata) && $stable(av_byteenable) &&
        $stable(av_read) && $stable(av_write)
  ) else $error("access_fsm: bus changed while waitrequest was high");

endmodule

/* logic/wait_timer.sv */
`timescale 1ns/1ns

module wait_timer (
  input  logic clk,
  input  logic reset,
  input  logic waiting,
  input  logic restart,
  output logic expired
);
  import bridge_pkg::*;

  logic [TIMER_WIDTH-1:0] count;  // wait cycles seen in the current access

  always_ff @(posedge clk)
  begin
    if (reset || restart)
    begin
      count <= '0;
    end
    else if (waiting && (count < BUS_TIMEOUT_CYCLES))
    begin
      count <= count + 1'b1;  // saturates at the limit
    end
  end

  assign expired = (count == BUS_TIMEOUT_CYCLES);

  // saturation keeps the count inside its range for the whole access
  a_count_bounded: assert property (
    @(posedge clk) disable iff (reset)
      count <= BUS_TIMEOUT_CYCLES
  ) else $error("wait_timer: count %0d above limit", count);

  // once expired, the fsm must leave the fetch state and restart the count
  a_expire_restarts: assert property (
    @(posedge clk) disable iff (reset)
      (expired && waiting) |=> !expired || restart || !waiting
  ) else $error("wait_timer: timeout not acted on");

endmodule

/* logic/lane_aligner.sv */
`timescale 1ns/1ns

module lane_aligner (
  input  logic              clk,
  input  logic              reset,
  input  bridge_pkg::word_t data_address,
  input  bridge_pkg::word_t data_writedata,
  input  bridge_pkg::word_t av_readdata,
  input  logic              capture_data,
  input  logic              capture_instr,
  aligned_req_if.aligner    req,
  output bridge_pkg::word_t data_readdata,
  output bridge_pkg::word_t instr_readdata
);
  import bridge_pkg::*;

  logic [4:0] shift_bits;  // offset in bits, always a multiple of 8

  assign req.address = {data_address[31:2], 2'b00};  // drop the byte offset
  assign req.offset  = data_address[1:0];
  assign shift_bits  = {req.offset, 3'b000};

  // lanes from the offset up to the top byte are enabled
  always_comb
  begin
    case (req.offset)
      2'b00:   req.byteenable = 4'b1111;
      2'b01:   req.byteenable = 4'b1110;
      2'b10:   req.byteenable = 4'b1100;
      default: req.byteenable = 4'b1000;
    endcase
  end

  assign req.writedata = data_writedata << shift_bits;  // low bytes move into addressed lanes

  // readback registers, loaded on the edge that completes an access
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      data_readdata  <= '0;
      instr_readdata <= '0;
    end
    else
    begin
      if (capture_data)
        data_readdata <= av_readdata >> shift_bits;  // addressed byte lands in bits 7:0
      if (capture_instr)
        instr_readdata <= av_readdata;  // instructions are always whole words
    end
  end

endmodule

/* logic/aligned_req_if.sv */
`timescale 1ns/1ns

interface aligned_req_if;
  import bridge_pkg::*;

  word_t    address;     // word-aligned data address
  word_t    writedata;   // write data moved into its lanes
  byte_en_t byteenable;
  offset_t  offset;      // byte offset stripped from the address

  modport aligner (
    output address,
    output writedata,
    output byteenable,
    output offset
  );

  modport fsm (
    input address,
    input writedata,
    input byteenable,
    input offset
  );

endinterface

/* logic/bridge_pkg.sv */
package bridge_pkg;

  // one bus word, used for addresses and data alike
  typedef logic [31:0] word_t;

  // one enable bit per byte lane
  typedef logic [3:0] byte_en_t;

  // byte position inside a word
  typedef logic [1:0] offset_t;

  // access sequencing states
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    FETCH_DATA  = 3'd1,  // data read or write on the bus
    INSTR_SET   = 3'd2,  // one turnaround cycle before the instruction read
    FETCH_INSTR = 3'd3,  // instruction read on the bus
    HALTED      = 3'd4   // one cycle with clk_enable high
  } bus_state_t;

  // consecutive waitrequest cycles before an access is abandoned
  localparam int BUS_TIMEOUT_CYCLES = 16;

  // enough bits to hold BUS_TIMEOUT_CYCLES itself
  localparam int TIMER_WIDTH = 5;

endpackage
